// ==== common/sms_loader_cfg.svh ====
// Widths, host index codes and record sizes for the download path
`ifndef SMS_LOADER_CFG_SVH
`define SMS_LOADER_CFG_SVH

// ==============================
// Address widths
// ==============================
`define SMS_HOST_AW 25 // Host loader byte address
`define SMS_ROM_AW 22 // ROM read side and size masks
`define SMS_WR_AW 24 // ROM write counter

// ==============================
// Host index codes
// ==============================
// Cartridge images use indexes 0 to 3
`define SMS_IDX_SYSMODE 4
`define SMS_IDX_DSW 254
`define SMS_IDX_CODE 255
`define SMS_IDX_GG 2 // Game Gear image
`define SMS_IDX_SYSE 3 // System E image

// ==============================
// Sizes
// ==============================
`define SMS_HDR_BYTES 512 // Copier header in front of some dumps
`define SMS_CHEAT_BYTES 16
`define SMS_DSW_COUNT 3

`endif

// ==== common/sms_loader_pkg.sv ====
// Types for the decoded host write, the cheat record and the system settings
`include "sms_loader_cfg.svh"

package sms_loader_pkg;

	// ==============================
	// Decoded host write
	// ==============================
	typedef struct packed {
		logic cart_wr; // ROM image byte
		logic code_wr; // Cheat record byte
		logic sysmode_wr;
		logic dsw_wr;
		logic dl_start; // Cart download began
		logic dl_end; // Cart download finished
		logic [7:0] data;
		logic [`SMS_HOST_AW-1:0] addr;
		logic [4:0] index; // Low bits of the host index
	} dl_cmd_t;

	// ==============================
	// Cheat record
	// ==============================
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Lane view is written by the loader, field view is read by the core.
	// Outer index picks the field from the top, inner index the byte from the LSB.
	typedef union packed {
		logic [0:3][3:0][7:0] lanes;
		cheat_fields_t fields;
	} cheat_code_u;

	typedef struct packed {
		logic valid; // One cycle when the last byte lands
		cheat_code_u code;
	} cheat_t;

	// ==============================
	// Decoded system settings
	// ==============================
	typedef struct packed {
		logic [1:0] encrypt; // Base and bank encryption enables
		logic has_paddle;
		logic has_pedal;
		logic [1:0] e0_type;
		logic e1_use;
		logic e2_use;
		logic [`SMS_DSW_COUNT-1:0][7:0] dsw;
		logic gg;
		logic systeme;
	} sys_cfg_t;

endpackage

// ==== design/download_decode.sv ====
// Host write register stage with index decode and cart download edge pulses
`include "sms_loader_cfg.svh"

module download_decode (
	input logic clk_sys,
	input logic rst,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic [7:0] ioctl_index,
	input logic [`SMS_HOST_AW-1:0] ioctl_addr,
	input logic [7:0] ioctl_dout,
	output sms_loader_pkg::dl_cmd_t cmd
);

	logic cart_dl;
	logic cart_dl_q; // Previous cart download level
	logic sysmode_hit;
	logic dsw_hit;

	// Indexes 0 to 3 are cartridge images
	assign cart_dl = ioctl_download & ~(|ioctl_index[7:2]);

	assign sysmode_hit = (ioctl_index == 8'(`SMS_IDX_SYSMODE)) && (ioctl_addr == '0);
	assign dsw_hit = (ioctl_index == 8'(`SMS_IDX_DSW)) && (ioctl_addr < `SMS_DSW_COUNT);

	// ==============================
	// Strobes and edge pulses
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_dl_q <= 1'b0;
			cmd.cart_wr <= 1'b0;
			cmd.code_wr <= 1'b0;
			cmd.sysmode_wr <= 1'b0;
			cmd.dsw_wr <= 1'b0;
			cmd.dl_start <= 1'b0;
			cmd.dl_end <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			cmd.cart_wr <= ioctl_wr & cart_dl;
			cmd.code_wr <= ioctl_wr & (ioctl_index == 8'(`SMS_IDX_CODE));
			cmd.sysmode_wr <= ioctl_wr & sysmode_hit;
			cmd.dsw_wr <= ioctl_wr & dsw_hit;
			cmd.dl_start <= cart_dl & ~cart_dl_q; // Rising edge
			cmd.dl_end <= ~cart_dl & cart_dl_q; // Falling edge
		end
	end

	// Payload follows the host every cycle
	always_ff @(posedge clk_sys) begin
		cmd.data <= ioctl_dout;
		cmd.addr <= ioctl_addr;
		cmd.index <= ioctl_index[4:0];
	end

endmodule

// ==== cart/cart_store.sv ====
// ROM write toggle handshake, host wait, cartridge size masks and read mapping
`include "sms_loader_cfg.svh"

module cart_store (
	input logic clk_sys,
	input logic rst,
	input sms_loader_pkg::dl_cmd_t cmd,
	input logic rom_ack,
	input logic [`SMS_ROM_AW-1:0] rom_rd_addr,
	output logic rom_req,
	output logic ioctl_wait,
	output logic [`SMS_WR_AW-1:0] rom_wr_addr,
	output logic [7:0] rom_wr_data,
	output logic [`SMS_ROM_AW-1:0] rom_map_addr
);

	logic [`SMS_WR_AW-1:0] wr_cnt;
	logic [`SMS_WR_AW-1:0] wr_total; // Bytes written, counting one in flight
	logic wr_done;
	logic [`SMS_ROM_AW-1:0] wr_addr; // Host address seen by the masks
	logic [`SMS_ROM_AW-1:0] hdr_off;
	logic [`SMS_ROM_AW-1:0] cart_mask;
	logic [`SMS_ROM_AW-1:0] cart_mask512;
	logic has_hdr;

	assign hdr_off = `SMS_HDR_BYTES;
	assign wr_addr = cmd.addr[`SMS_ROM_AW-1:0];

	// Memory has caught up with the last toggle
	assign wr_done = ioctl_wait && (rom_ack == rom_req);
	assign wr_total = wr_cnt + {{(`SMS_WR_AW-1){1'b0}}, ioctl_wait};

	// ==============================
	// Write handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (cmd.cart_wr) begin
			rom_req <= ~rom_req; // New request on every level change
			ioctl_wait <= 1'b1;
		end else if (wr_done) begin
			ioctl_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_cnt <= '0;
		end else if (cmd.dl_start) begin
			wr_cnt <= '0;
		end else if (wr_done) begin
			wr_cnt <= wr_cnt + {{(`SMS_WR_AW-1){1'b0}}, 1'b1};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cmd.cart_wr)
			rom_wr_data <= cmd.data; // Held until the next request
	end

	assign rom_wr_addr = wr_cnt;

	// ==============================
	// Size masks and header flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_mask <= '0;
			cart_mask512 <= '0;
			has_hdr <= 1'b0;
		end else begin
			if (cmd.cart_wr) begin
				if (cmd.addr == '0)
					cart_mask <= '0;
				else
					cart_mask <= cart_mask | wr_addr;
				// Same rule for the image behind a header
				if (cmd.addr == `SMS_HDR_BYTES)
					cart_mask512 <= '0;
				else
					cart_mask512 <= cart_mask512 | (wr_addr - hdr_off);
			end
			if (cmd.dl_end)
				has_hdr <= wr_total[$clog2(`SMS_HDR_BYTES)]; // Odd multiple of 512
		end
	end

	// Console read translation
	assign rom_map_addr = has_hdr ? ((rom_rd_addr + hdr_off) & cart_mask512)
		: (rom_rd_addr & cart_mask);

	// ==============================
	// Checks
	// ==============================
	// Host honours the wait level
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (rst)
		cmd.cart_wr |-> !ioctl_wait);

	// Memory sees a steady write while the toggle is open
	a_wr_stable: assert property (@(posedge clk_sys) disable iff (rst)
		(rom_req != rom_ack) |=> ($stable(rom_wr_addr) && $stable(rom_wr_data)));

endmodule

// ==== design/cheat_assembler.sv ====
// Cheat record assembly from host bytes with a one cycle valid pulse
`include "sms_loader_cfg.svh"

module cheat_assembler (
	input logic clk_sys,
	input logic rst,
	input sms_loader_pkg::dl_cmd_t cmd,
	output sms_loader_pkg::cheat_t cheat
);

	logic [3:0] lane;
	logic last_lane;

	assign lane = cmd.addr[3:0]; // Byte position within the record
	assign last_lane = (lane == 4'(`SMS_CHEAT_BYTES - 1));

	// ==============================
	// Record bytes
	// ==============================
	// Upper two bits pick the field, lower two the byte in it
	always_ff @(posedge clk_sys) begin
		if (cmd.code_wr)
			cheat.code.lanes[lane[3:2]][lane[1:0]] <= cmd.data;
	end

	// Record complete with the replace top byte
	always_ff @(posedge clk_sys) begin
		if (rst)
			cheat.valid <= 1'b0;
		else
			cheat.valid <= cmd.code_wr & last_lane;
	end

	// ==============================
	// Checks
	// ==============================
	// A pulse per record, even with back to back records
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		cheat.valid |=> !cheat.valid);

endmodule

// ==== design/system_config.sv ====
// System mode and DIP switch registers with cartridge type flags
`include "sms_loader_cfg.svh"

module system_config (
	input logic clk_sys,
	input logic rst,
	input sms_loader_pkg::dl_cmd_t cmd,
	output sms_loader_pkg::sys_cfg_t cfg
);

	logic [7:0] sysmode_q;
	logic [`SMS_DSW_COUNT-1:0][7:0] dsw_q;
	logic gg_q;
	logic systeme_q;

	// ==============================
	// Raw registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sysmode_q <= '0;
			dsw_q <= '0;
			gg_q <= 1'b0;
			systeme_q <= 1'b0;
		end else begin
			if (cmd.dsw_wr)
				dsw_q[cmd.addr[1:0]] <= cmd.data; // Address already below the count
			// Each image byte restates the cart type
			if (cmd.cart_wr) begin
				gg_q <= (cmd.index == 5'(`SMS_IDX_GG));
				systeme_q <= (cmd.index == 5'(`SMS_IDX_SYSE));
			end
			if (cmd.sysmode_wr) begin
				sysmode_q <= cmd.data;
				systeme_q <= 1'b1; // Only arcade sets carry a mode byte
			end
		end
	end

	// Mode byte split into named settings
	always_comb begin
		cfg.encrypt = sysmode_q[1:0];
		cfg.has_paddle = sysmode_q[2];
		cfg.has_pedal = sysmode_q[3];
		cfg.e0_type = sysmode_q[5:4];
		cfg.e1_use = sysmode_q[6];
		cfg.e2_use = sysmode_q[7];
		cfg.dsw = dsw_q;
		cfg.gg = gg_q;
		cfg.systeme = systeme_q;
	end

endmodule

// ==== design/sms_loader_top.sv ====
// Download path top level with decode, cart store, cheat and config blocks
`include "sms_loader_cfg.svh"

module sms_loader_top (
	input logic clk_sys,
	input logic rst,
	// Host loader
	input logic ioctl_download,
	input logic [7:0] ioctl_index,
	input logic [`SMS_HOST_AW-1:0] ioctl_addr,
	input logic [7:0] ioctl_dout,
	input logic ioctl_wr,
	output logic ioctl_wait,
	// ROM memory
	output logic rom_req,
	input logic rom_ack,
	output logic [`SMS_WR_AW-1:0] rom_wr_addr,
	output logic [7:0] rom_wr_data,
	input logic [`SMS_ROM_AW-1:0] rom_rd_addr,
	output logic [`SMS_ROM_AW-1:0] rom_map_addr,
	// Results
	output sms_loader_pkg::cheat_t cheat,
	output sms_loader_pkg::sys_cfg_t cfg
);

	sms_loader_pkg::dl_cmd_t cmd; // Shared by every block

	download_decode u_download_decode (
		.clk_sys(clk_sys),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.cmd(cmd)
	);

	cart_store u_cart_store (
		.clk_sys(clk_sys),
		.rst(rst),
		.cmd(cmd),
		.rom_ack(rom_ack),
		.rom_rd_addr(rom_rd_addr),
		.rom_req(rom_req),
		.ioctl_wait(ioctl_wait),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.rom_map_addr(rom_map_addr)
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys(clk_sys),
		.rst(rst),
		.cmd(cmd),
		.cheat(cheat)
	);

	system_config u_system_config (
		.clk_sys(clk_sys),
		.rst(rst),
		.cmd(cmd),
		.cfg(cfg)
	);

endmodule

// ==== tb/sms_loader_tb.sv ====
// Testbench for the download path with a toggle handshake ROM model and directed tests
`include "sms_loader_cfg.svh"

module sms_loader_tb;

	localparam int WAIT_LIMIT = 40; // Cycles per bounded wait

	logic clk_sys;
	logic rst;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic [`SMS_HOST_AW-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic ioctl_wr;
	logic ioctl_wait;
	logic rom_req;
	logic rom_ack;
	logic [`SMS_WR_AW-1:0] rom_wr_addr;
	logic [7:0] rom_wr_data;
	logic [`SMS_ROM_AW-1:0] rom_rd_addr;
	logic [`SMS_ROM_AW-1:0] rom_map_addr;
	sms_loader_pkg::cheat_t cheat;
	sms_loader_pkg::sys_cfg_t cfg;

	integer seed = 32'h85; // Stimulus
	integer rom_seed = 32'h85; // ROM latency
	int checks = 0;
	int errors = 0;
	int test_start = 0;
	int valid_cnt = 0;
	logic rom_hold = 1'b0; // ROM model keeps the request open
	string cur_test = "init";
	logic [7:0] cart_bytes [0:2047];
	logic [`SMS_WR_AW-1:0] rec_addr [$];
	logic [7:0] rec_data [$];

	sms_loader_top u_sms_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==============================
	// ROM model
	// ==============================
	// Sees a toggle one edge late, then acks after 1 to 6 cycles
	initial begin : rom_model
		int delay;
		rom_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (rst) begin
				rom_ack <= 1'b0;
			end else if (rom_req != rom_ack && !rom_hold) begin
				rec_addr.push_back(rom_wr_addr);
				rec_data.push_back(rom_wr_data);
				delay = 1 + int'($unsigned($random(rom_seed)) % 6);
				repeat (delay - 1) @(posedge clk_sys);
				rom_ack <= rom_req;
			end
		end
	end

	always @(posedge clk_sys) begin
		if (cheat.valid)
			valid_cnt++; // Pre-edge value
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic fail_on_timeout(input string what);
		$display("Timeout in %s while waiting for %s", cur_test, what);
		$display("Test failed");
		$finish;
	endtask

	task automatic finish_test();
		$display("%s done with %0d errors", cur_test, errors - test_start);
	endtask

	task automatic settle(input int n);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic host_write(input logic [7:0] idx, input int addr, input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_index <= idx;
		ioctl_addr <= addr[`SMS_HOST_AW-1:0];
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// Wait rises two edges after the host write, then falls after the ack
	task automatic wait_ready();
		int n;
		n = 0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		while (ioctl_wait && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait)
			fail_on_timeout("ioctl_wait to fall");
	endtask

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_sys);
		ioctl_index <= idx;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic stop_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		settle(3);
	endtask

	task automatic load_cart(input int n, input logic [7:0] idx);
		start_download(idx);
		for (int i = 0; i < n; i++) begin
			cart_bytes[i] = 8'($random(seed));
			host_write(idx, i, cart_bytes[i]);
			wait_ready();
		end
		stop_download();
	endtask

	task automatic check_map(input logic hdr);
		logic [31:0] r;
		logic [`SMS_ROM_AW-1:0] rd;
		logic [`SMS_ROM_AW-1:0] exp;
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			rd = r[`SMS_ROM_AW-1:0];
			exp = hdr ? ((rd + 22'd512) & 22'h3FF) : (rd & 22'h3FF);
			@(posedge clk_sys);
			rom_rd_addr <= rd;
			@(negedge clk_sys);
			check_value("rom_map_addr", exp, rom_map_addr);
		end
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic test_cart_download();
		cur_test = "cart_download";
		test_start = errors;
		rec_addr.delete();
		rec_data.delete();
		load_cart(1024, 8'd0);
		check_value("write count", 1024, rec_addr.size());
		for (int i = 0; i < rec_addr.size() && i < 1024; i++) begin
			check_value("write address", i, rec_addr[i]);
			check_value("write data", cart_bytes[i], rec_data[i]);
		end
		check_value("ioctl_wait", 0, ioctl_wait);
		finish_test();
	endtask

	task automatic test_masks();
		cur_test = "masks";
		test_start = errors;
		load_cart(1024, 8'd0);
		check_value("header flag", 0, u_sms_loader_top.u_cart_store.has_hdr);
		check_map(1'b0);
		load_cart(1536, 8'd0); // Image behind a 512 byte header
		check_value("header flag", 1, u_sms_loader_top.u_cart_store.has_hdr);
		check_map(1'b1);
		finish_test();
	endtask

	task automatic test_cheat();
		logic [7:0] b [0:15];
		logic [31:0] exp_f [0:3];
		int start_cnt;
		int n;
		cur_test = "cheat";
		test_start = errors;
		start_cnt = valid_cnt;
		for (int k = 0; k < `SMS_CHEAT_BYTES; k++) begin
			b[k] = 8'($random(seed));
			exp_f[k / 4][8 * (k % 4) +: 8] = b[k]; // Field k/4, LSB first
		end
		start_download(8'(`SMS_IDX_CODE));
		for (int k = 0; k < `SMS_CHEAT_BYTES; k++)
			host_write(8'(`SMS_IDX_CODE), k, b[k]);
		n = 0;
		@(negedge clk_sys);
		while (!cheat.valid && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cheat.valid)
			fail_on_timeout("cheat.valid");
		check_value("flags", exp_f[0], cheat.code.fields.flags);
		check_value("address", exp_f[1], cheat.code.fields.address);
		check_value("compare", exp_f[2], cheat.code.fields.compare);
		check_value("replace", exp_f[3], cheat.code.fields.replace);
		stop_download();
		check_value("valid pulses", 1, valid_cnt - start_cnt);
		finish_test();
	endtask

	task automatic test_sysconfig();
		logic [7:0] mode;
		logic [7:0] dsw [0:2];
		cur_test = "sysconfig";
		test_start = errors;
		mode = 8'($random(seed));
		host_write(8'(`SMS_IDX_SYSMODE), 0, mode);
		settle(2);
		check_value("encrypt", mode[1:0], cfg.encrypt);
		check_value("has_paddle", mode[2], cfg.has_paddle);
		check_value("has_pedal", mode[3], cfg.has_pedal);
		check_value("e0_type", mode[5:4], cfg.e0_type);
		check_value("e1_use", mode[6], cfg.e1_use);
		check_value("e2_use", mode[7], cfg.e2_use);
		check_value("systeme", 1, cfg.systeme);
		for (int i = 0; i < `SMS_DSW_COUNT; i++) begin
			dsw[i] = 8'($random(seed));
			host_write(8'(`SMS_IDX_DSW), i, dsw[i]);
			settle(2);
			check_value("dsw byte", dsw[i], cfg.dsw[i]);
		end
		check_value("dsw word", {dsw[2], dsw[1], dsw[0]}, cfg.dsw);
		// Game Gear image replaces the arcade flag
		load_cart(1, 8'(`SMS_IDX_GG));
		check_value("gg", 1, cfg.gg);
		check_value("systeme", 0, cfg.systeme);
		finish_test();
	endtask

	task automatic test_reset_mid_load();
		cur_test = "reset_mid_load";
		test_start = errors;
		start_download(8'd0);
		// Bring rom_req low first so the open request leaves it high
		if (rom_req) begin
			host_write(8'd0, 0, 8'($random(seed)));
			wait_ready();
		end
		rom_hold = 1'b1;
		host_write(8'd0, 1, 8'($random(seed)));
		settle(1);
		check_value("ioctl_wait before reset", 1, ioctl_wait);
		check_value("rom_req before reset", 1, rom_req);
		@(posedge clk_sys);
		rst <= 1'b1;
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		rom_hold = 1'b0;
		check_value("ioctl_wait", 0, ioctl_wait);
		check_value("rom_req", 0, rom_req);
		check_value("cheat.valid", 0, cheat.valid);
		check_value("cfg", 0, cfg);
		finish_test();
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		ioctl_wr = 1'b0;
		rom_rd_addr = '0;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		@(posedge clk_sys);
		test_cart_download();
		test_masks();
		test_cheat();
		test_sysconfig();
		test_reset_mid_load();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+common
common/sms_loader_pkg.sv
design/download_decode.sv
cart/cart_store.sv
design/cheat_assembler.sv
design/system_config.sv
design/sms_loader_top.sv
tb/sms_loader_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := sms_loader_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
HEADERS  := common/sms_loader_cfg.svh
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Test passed

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
